// File: Makefile
# Verilator simulation of the cpuDatapath project

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := cpuDatapathTb
FILELIST := cpuDatapath.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cpuDatapath.f
design/datapathPkg.sv
design/registerFile.sv
design/busUnit.sv
design/aluUnit.sv
design/shiftCounter.sv
design/controlSequencer.sv
design/cpuDatapath.sv
sim/cpuDatapathAsserts.sv
sim/cpuDatapathTb.sv

// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [datapathPkg::wordWidth-1:0] busIn,
    input  logic                              yLoad,
    input  logic                              zLoad,
    input  logic                              zShift,
    input  logic                              hiLoLoad,
    input  datapathPkg::opcodeT               aluOp,
    output logic [datapathPkg::wordWidth-1:0] yOut,
    output logic [datapathPkg::wordWidth-1:0] zLow,
    output logic [datapathPkg::wordWidth-1:0] zHigh,
    output logic [datapathPkg::wordWidth-1:0] hi,
    output logic [datapathPkg::wordWidth-1:0] lo
);

    logic [2*datapathPkg::wordWidth-1:0] aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            yOut <= '0;
        end else if (yLoad) begin
            yOut <= busIn;
        end
    end

    // Y on one side, the bus on the other
    always_comb begin
        case (aluOp)
            datapathPkg::opAdd: begin
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut + busIn};
            end
            datapathPkg::opSub: begin
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut - busIn};
            end
            datapathPkg::opAnd: begin
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut & busIn};
            end
            datapathPkg::opOr: begin
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut | busIn};
            end
            datapathPkg::opMul: begin   // Unsigned 64-bit product
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut}
                          * {{datapathPkg::wordWidth{1'b0}}, busIn};
            end
            default: begin
                aluResult = {{datapathPkg::wordWidth{1'b0}}, yOut};   // Shift start value
            end
        endcase
    end

    // Z loads the result or shifts its low half in place
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            zHigh <= '0;
            zLow  <= '0;
        end else if (zLoad) begin
            {zHigh, zLow} <= aluResult;
        end else if (zShift) begin
            case (aluOp)
                datapathPkg::opShl: zLow <= zLow << 1;
                datapathPkg::opShr: zLow <= zLow >> 1;
                datapathPkg::opRor: zLow <= {zLow[0], zLow[datapathPkg::wordWidth-1:1]};
                default:            zLow <= zLow;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else if (hiLoLoad) begin
            hi <= zHigh;
            lo <= zLow;
        end
    end

endmodule

// File: design/busUnit.sv
`timescale 1ns/1ps

module busUnit (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [datapathPkg::wordWidth-1:0] loadData,
    input  logic                              mdrLoad,
    input  datapathPkg::busSrcT               busSrc,
    input  logic [datapathPkg::wordWidth-1:0] regOut,
    input  logic [datapathPkg::wordWidth-1:0] yOut,
    input  logic [datapathPkg::wordWidth-1:0] zLow,
    input  logic [datapathPkg::wordWidth-1:0] zHigh,
    output logic [datapathPkg::wordWidth-1:0] busOut
);

    logic [datapathPkg::wordWidth-1:0] mdr;

    // MDR takes the memory-in word
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdr <= '0;
        end else if (mdrLoad) begin
            mdr <= loadData;
        end
    end

    // Single internal bus, one source at a time
    always_comb begin
        case (busSrc)
            datapathPkg::srcReg: begin
                busOut = regOut;
            end
            datapathPkg::srcMdr: begin
                busOut = mdr;
            end
            datapathPkg::srcZLow: begin
                busOut = zLow;
            end
            datapathPkg::srcZHigh: begin
                busOut = zHigh;
            end
            datapathPkg::srcY: begin
                busOut = yOut;
            end
            default: begin
                busOut = '0;   // Idle bus
            end
        endcase
    end

endmodule

// File: design/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                load,
    input  logic                                start,
    input  logic [datapathPkg::regIdxWidth-1:0] loadReg,
    input  logic [datapathPkg::regIdxWidth-1:0] ra,
    input  logic [datapathPkg::regIdxWidth-1:0] rb,
    input  logic [datapathPkg::regIdxWidth-1:0] rc,
    input  datapathPkg::opcodeT                 opcode,
    input  logic                                cntZero,
    output datapathPkg::busSrcT                 busSrc,
    output logic [datapathPkg::regIdxWidth-1:0] busReg,
    output logic [datapathPkg::regIdxWidth-1:0] regWriteIdx,
    output logic                                regWrite,
    output logic                                mdrLoad,
    output logic                                yLoad,
    output logic                                zLoad,
    output logic                                zShift,
    output logic                                hiLoLoad,
    output logic                                cntLoad,
    output datapathPkg::opcodeT                 aluOp,
    output logic                                busy,
    output logic                                done
);

    datapathPkg::seqStateT state;
    datapathPkg::seqStateT nextState;

    // Captured command fields
    datapathPkg::opcodeT                 opQ;
    logic [datapathPkg::regIdxWidth-1:0] dstQ;   // Ra, or the preload target
    logic [datapathPkg::regIdxWidth-1:0] rbQ;
    logic [datapathPkg::regIdxWidth-1:0] rcQ;
    logic                                isShift;

    assign isShift = (opQ == datapathPkg::opShl) || (opQ == datapathPkg::opShr)
                  || (opQ == datapathPkg::opRor);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= datapathPkg::stIdle;
            opQ   <= datapathPkg::opAdd;
            dstQ  <= '0;
            rbQ   <= '0;
            rcQ   <= '0;
        end else begin
            state <= nextState;
            if (state == datapathPkg::stIdle) begin
                if (start) begin   // Start wins over load
                    opQ  <= opcode;
                    dstQ <= ra;
                    rbQ  <= rb;
                    rcQ  <= rc;
                end else if (load) begin
                    dstQ <= loadReg;
                end
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            datapathPkg::stIdle: begin
                if (start) begin
                    nextState = datapathPkg::stT1;
                end else if (load) begin
                    nextState = datapathPkg::stLoadReg;
                end
            end
            datapathPkg::stLoadReg: nextState = datapathPkg::stT4;
            datapathPkg::stT1:      nextState = datapathPkg::stT2;
            datapathPkg::stT2:      nextState = isShift ? datapathPkg::stShift : datapathPkg::stT3;
            datapathPkg::stShift: begin
                if (cntZero) begin
                    nextState = datapathPkg::stT3;
                end
            end
            datapathPkg::stT3:      nextState = datapathPkg::stT4;
            default:                nextState = datapathPkg::stIdle;
        endcase
    end

    // Per-step strobes
    always_comb begin
        busSrc   = datapathPkg::srcNone;
        regWrite = 1'b0;
        mdrLoad  = 1'b0;
        yLoad    = 1'b0;
        zLoad    = 1'b0;
        zShift   = 1'b0;
        hiLoLoad = 1'b0;
        cntLoad  = 1'b0;
        case (state)
            datapathPkg::stIdle: begin
                mdrLoad = load && !start;   // Memory-in word is only valid with the strobe
            end
            datapathPkg::stLoadReg: begin
                busSrc   = datapathPkg::srcMdr;
                regWrite = 1'b1;
            end
            datapathPkg::stT1: begin   // Rb out, Yin
                busSrc = datapathPkg::srcReg;
                yLoad  = 1'b1;
            end
            datapathPkg::stT2: begin   // Rc out, Zin
                busSrc  = datapathPkg::srcReg;
                zLoad   = 1'b1;
                cntLoad = isShift;
            end
            datapathPkg::stShift: begin
                zShift = !cntZero;
            end
            datapathPkg::stT3: begin
                if (opQ == datapathPkg::opMul) begin
                    hiLoLoad = 1'b1;
                end else begin
                    busSrc   = datapathPkg::srcZLow;
                    regWrite = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign busReg      = (state == datapathPkg::stT1) ? rbQ : rcQ;
    assign regWriteIdx = dstQ;
    assign aluOp       = opQ;
    assign busy        = (state != datapathPkg::stIdle);
    assign done        = (state == datapathPkg::stT4);

endmodule

// File: design/cpuDatapath.sv
`timescale 1ns/1ps

module cpuDatapath (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                load,
    input  logic [datapathPkg::wordWidth-1:0]   loadData,
    input  logic [datapathPkg::regIdxWidth-1:0] loadReg,
    input  logic                                start,
    input  datapathPkg::opcodeT                 opcode,
    input  logic [datapathPkg::regIdxWidth-1:0] ra,
    input  logic [datapathPkg::regIdxWidth-1:0] rb,
    input  logic [datapathPkg::regIdxWidth-1:0] rc,
    output logic                                busy,
    output logic                                done,
    input  logic [datapathPkg::regIdxWidth-1:0] readSel,
    output logic [datapathPkg::wordWidth-1:0]   readData,
    output logic [datapathPkg::wordWidth-1:0]   hi,
    output logic [datapathPkg::wordWidth-1:0]   lo
);

    datapathPkg::busSrcT                 busSrc;
    datapathPkg::opcodeT                 aluOp;
    logic [datapathPkg::regIdxWidth-1:0] busReg;
    logic [datapathPkg::regIdxWidth-1:0] regWriteIdx;
    logic                                regWrite;
    logic                                mdrLoad;
    logic                                yLoad;
    logic                                zLoad;
    logic                                zShift;
    logic                                hiLoLoad;
    logic                                cntLoad;
    logic                                cntZero;
    logic [datapathPkg::wordWidth-1:0]   busOut;
    logic [datapathPkg::wordWidth-1:0]   regOut;
    logic [datapathPkg::wordWidth-1:0]   yOut;
    logic [datapathPkg::wordWidth-1:0]   zLow;
    logic [datapathPkg::wordWidth-1:0]   zHigh;

    controlSequencer seq0 (
        .clk(clk),
        .arstN(arstN),
        .load(load),
        .start(start),
        .loadReg(loadReg),
        .ra(ra),
        .rb(rb),
        .rc(rc),
        .opcode(opcode),
        .cntZero(cntZero),
        .busSrc(busSrc),
        .busReg(busReg),
        .regWriteIdx(regWriteIdx),
        .regWrite(regWrite),
        .mdrLoad(mdrLoad),
        .yLoad(yLoad),
        .zLoad(zLoad),
        .zShift(zShift),
        .hiLoLoad(hiLoLoad),
        .cntLoad(cntLoad),
        .aluOp(aluOp),
        .busy(busy),
        .done(done)
    );

    // Shift amount comes from the low bits of Rc on the bus
    shiftCounter cnt0 (
        .clk(clk),
        .arstN(arstN),
        .cntLoad(cntLoad),
        .loadValue(busOut[datapathPkg::shiftWidth-1:0]),
        .cntZero(cntZero)
    );

    busUnit bus0 (
        .clk(clk),
        .arstN(arstN),
        .loadData(loadData),
        .mdrLoad(mdrLoad),
        .busSrc(busSrc),
        .regOut(regOut),
        .yOut(yOut),
        .zLow(zLow),
        .zHigh(zHigh),
        .busOut(busOut)
    );

    registerFile regs0 (
        .clk(clk),
        .arstN(arstN),
        .busIn(busOut),
        .regWrite(regWrite),
        .regWriteIdx(regWriteIdx),
        .busReg(busReg),
        .regOut(regOut),
        .readSel(readSel),
        .readData(readData)
    );

    aluUnit alu0 (
        .clk(clk),
        .arstN(arstN),
        .busIn(busOut),
        .yLoad(yLoad),
        .zLoad(zLoad),
        .zShift(zShift),
        .hiLoLoad(hiLoLoad),
        .aluOp(aluOp),
        .yOut(yOut),
        .zLow(zLow),
        .zHigh(zHigh),
        .hi(hi),
        .lo(lo)
    );

endmodule

// File: design/datapathPkg.sv
package datapathPkg;

    // Widths fixed by the instruction format
    localparam int wordWidth   = 32;
    localparam int regIdxWidth = 4;
    localparam int shiftWidth  = 5;   // Covers amounts 0 to 31

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opMul,
        opShl,
        opShr,
        opRor
    } opcodeT;

    // Sources that may drive the internal bus
    typedef enum logic [2:0] {
        srcNone,
        srcReg,
        srcMdr,
        srcZLow,
        srcZHigh,
        srcY
    } busSrcT;

    typedef enum logic [3:0] {
        stIdle,
        stLoadReg,
        stT1,
        stT2,
        stShift,
        stT3,
        stT4
    } seqStateT;

endpackage

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [datapathPkg::wordWidth-1:0]  busIn,
    input  logic                               regWrite,
    input  logic [datapathPkg::regIdxWidth-1:0] regWriteIdx,
    input  logic [datapathPkg::regIdxWidth-1:0] busReg,
    output logic [datapathPkg::wordWidth-1:0]  regOut,
    input  logic [datapathPkg::regIdxWidth-1:0] readSel,
    output logic [datapathPkg::wordWidth-1:0]  readData
);

    // R0 to R15
    logic [datapathPkg::wordWidth-1:0] regs [2**datapathPkg::regIdxWidth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**datapathPkg::regIdxWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[regWriteIdx] <= busIn;   // Rin strobe from the sequencer
        end
    end

    // Register that drives the bus when the bus select names the file
    assign regOut = regs[busReg];

    // Observation port
    assign readData = regs[readSel];

endmodule

// File: design/shiftCounter.sv
`timescale 1ns/1ps

module shiftCounter (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               cntLoad,
    input  logic [datapathPkg::shiftWidth-1:0] loadValue,
    output logic                               cntZero
);

    logic [datapathPkg::shiftWidth-1:0] count;

    // Steps left in the current shift
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (cntLoad) begin
            count <= loadValue;
        end else if (!cntZero) begin
            count <= count - 1'b1;
        end
    end

    assign cntZero = (count == '0);

endmodule

// File: sim/cpuDatapathAsserts.sv
`timescale 1ns/1ps

module cpuDatapathAsserts (
    input logic clk,
    input logic arstN,
    input logic busy,
    input logic done
);

    // A done pulse always closes a command that was already running
    doneNeedsBusy: assert property (@(posedge clk) disable iff (!arstN) done |-> $past(busy))
        else $error("done seen without a command in progress");

    doneOneCycle: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else $error("done held for more than one cycle");

    // Idle while reset is held and on the first cycle out of it
    idleInReset: assert property (@(posedge clk) !arstN |-> (!busy && !done))
        else $error("busy or done high during reset");

    idleAfterReset: assert property (@(posedge clk) $rose(arstN) |-> (!busy && !done))
        else $error("busy or done high right after reset");

endmodule

bind cpuDatapath cpuDatapathAsserts asserts0 (
    .clk(clk),
    .arstN(arstN),
    .busy(busy),
    .done(done)
);

// File: sim/cpuDatapathTb.sv
`timescale 1ns/1ps

module cpuDatapathTb;

    logic                                clk;
    logic                                arstN;
    logic                                load;
    logic [datapathPkg::wordWidth-1:0]   loadData;
    logic [datapathPkg::regIdxWidth-1:0] loadReg;
    logic                                start;
    datapathPkg::opcodeT                 opcode;
    logic [datapathPkg::regIdxWidth-1:0] ra;
    logic [datapathPkg::regIdxWidth-1:0] rb;
    logic [datapathPkg::regIdxWidth-1:0] rc;
    logic                                busy;
    logic                                done;
    logic [datapathPkg::regIdxWidth-1:0] readSel;
    logic [datapathPkg::wordWidth-1:0]   readData;
    logic [datapathPkg::wordWidth-1:0]   hi;
    logic [datapathPkg::wordWidth-1:0]   lo;

    // Reference model state
    logic [datapathPkg::wordWidth-1:0] model [2**datapathPkg::regIdxWidth];
    logic [datapathPkg::wordWidth-1:0] modelHi;
    logic [datapathPkg::wordWidth-1:0] modelLo;
    int checkErrors;
    int timeoutErrors;

    cpuDatapath dut0 (
        .clk(clk),
        .arstN(arstN),
        .load(load),
        .loadData(loadData),
        .loadReg(loadReg),
        .start(start),
        .opcode(opcode),
        .ra(ra),
        .rb(rb),
        .rc(rc),
        .busy(busy),
        .done(done),
        .readSel(readSel),
        .readData(readData),
        .hi(hi),
        .lo(lo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Y is the Rb value, c the Rc value; mul fills all 64 bits
    function automatic logic [63:0] expectedResult(input datapathPkg::opcodeT op,
                                                   input logic [31:0] y, input logic [31:0] c);
        logic [4:0] amount;
        amount = c[datapathPkg::shiftWidth-1:0];
        case (op)
            datapathPkg::opAdd: return {32'b0, y + c};
            datapathPkg::opSub: return {32'b0, y - c};
            datapathPkg::opAnd: return {32'b0, y & c};
            datapathPkg::opOr:  return {32'b0, y | c};
            datapathPkg::opMul: return {32'b0, y} * {32'b0, c};
            datapathPkg::opShl: return {32'b0, y << amount};
            datapathPkg::opShr: return {32'b0, y >> amount};
            default:            return {32'b0, (y >> amount) | (y << (6'd32 - amount))};
        endcase
    endfunction

    task automatic endRun();
        $display("Summary: %0d check errors, %0d timeouts", checkErrors, timeoutErrors);
        if (checkErrors == 0 && timeoutErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        assert (got === expected) else begin
            checkErrors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // done is sampled mid-cycle where it is stable
    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (cycles < 100) begin
            @(negedge clk);
            if (done) begin
                return;
            end
            assert (busy) else begin   // Busy from the cycle after the strobe
                checkErrors++;
                $display("[FAIL] %0t: busy is low while a command runs", $time);
            end
            cycles++;
        end
        timeoutErrors++;
        $display("Timeout at %0t: done did not arrive within 100 cycles", $time);
        endRun();
    endtask

    task automatic sendStrobe(input logic doLoad, input logic doStart,
                              input logic [31:0] data, input logic [3:0] dst,
                              input datapathPkg::opcodeT op,
                              input logic [3:0] a, input logic [3:0] b, input logic [3:0] c);
        @(posedge clk);
        #2;
        load     = doLoad;
        start    = doStart;
        loadData = data;
        loadReg  = dst;
        opcode   = op;
        ra       = a;
        rb       = b;
        rc       = c;
        @(posedge clk);
        #2;
        load  = 1'b0;
        start = 1'b0;
    endtask

    task automatic compareAll(input string what);
        for (int i = 0; i < 2**datapathPkg::regIdxWidth; i++) begin
            @(posedge clk);
            #2;
            readSel = 4'(i);
            @(negedge clk);
            checkValue(readData, model[i], $sformatf("R%0d after %s", i, what));
        end
        checkValue(hi, modelHi, {"HI after ", what});
        checkValue(lo, modelLo, {"LO after ", what});
    endtask

    // New value must already show on readData while done is high
    task automatic preloadReg(input logic [3:0] dst, input logic [31:0] data);
        sendStrobe(1'b1, 1'b0, data, dst, datapathPkg::opAdd, 4'd0, 4'd0, 4'd0);
        readSel = dst;
        waitDone();
        checkValue(readData, data, $sformatf("R%0d at preload done", dst));
        model[dst] = data;
    endtask

    task automatic runCommand(input datapathPkg::opcodeT op,
                              input logic [3:0] a, input logic [3:0] b, input logic [3:0] c);
        logic [63:0] result;
        result = expectedResult(op, model[b], model[c]);   // Sources read before Ra changes
        sendStrobe(1'b0, 1'b1, 32'h0, 4'd0, op, a, b, c);
        waitDone();
        if (op == datapathPkg::opMul) begin
            modelHi = result[63:32];
            modelLo = result[31:0];
        end else begin
            model[a] = result[31:0];
        end
        compareAll(op.name());
    endtask

    initial begin
        logic [3:0]  a;
        logic [3:0]  b;
        logic [3:0]  c;
        logic [4:0]  amount;
        logic [63:0] result;
        void'($urandom(32'hedeb_ec40));
        arstN    = 1'b0;
        load     = 1'b0;
        loadData = '0;
        loadReg  = '0;
        start    = 1'b0;
        opcode   = datapathPkg::opAdd;
        ra       = '0;
        rb       = '0;
        rc       = '0;
        readSel  = '0;
        checkErrors   = 0;
        timeoutErrors = 0;
        modelHi = '0;
        modelLo = '0;
        for (int i = 0; i < 2**datapathPkg::regIdxWidth; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;

        assert (!busy) else begin
            checkErrors++;
            $display("[FAIL] %0t: busy is high after reset", $time);
        end
        compareAll("reset");

        for (int i = 0; i < 2**datapathPkg::regIdxWidth; i++) begin
            preloadReg(4'(i), $urandom());
        end
        compareAll("preload");

        // add, sub, and, or with Ra aliasing Rb or Rc now and then
        for (int i = 0; i < 60; i++) begin
            a = 4'($urandom());
            b = (i % 5 == 0) ? a : 4'($urandom());
            c = (i % 5 == 1) ? a : 4'($urandom());
            runCommand(datapathPkg::opcodeT'(3'($urandom_range(3, 0))), a, b, c);
        end

        for (int i = 0; i < 20; i++) begin
            runCommand(datapathPkg::opMul, 4'($urandom()), 4'($urandom()), 4'($urandom()));
        end

        // Shift amount rides in the low bits of Rc
        for (int i = 0; i < 45; i++) begin
            amount = (i < 3) ? 5'd0 : (i < 6) ? 5'd31 : 5'($urandom());
            c = 4'($urandom());
            preloadReg(c, {27'($urandom()), amount});
            runCommand(datapathPkg::opcodeT'(3'(5 + i % 3)), 4'($urandom()),
                       4'($urandom()), c);
        end

        // Long shift keeps the DUT busy while a load and a start arrive
        preloadReg(4'd2, 32'h0000_001f);
        result = expectedResult(datapathPkg::opShl, model[4], model[2]);
        sendStrobe(1'b0, 1'b1, 32'h0, 4'd0, datapathPkg::opShl, 4'd3, 4'd4, 4'd2);
        sendStrobe(1'b1, 1'b0, $urandom(), 4'd5, datapathPkg::opAdd, 4'd0, 4'd0, 4'd0);
        sendStrobe(1'b0, 1'b1, 32'h0, 4'd0, datapathPkg::opSub, 4'd4, 4'd3, 4'd3);
        waitDone();
        model[3] = result[31:0];
        compareAll("strobes while busy");

        // Start wins over a load in the same cycle
        result = expectedResult(datapathPkg::opOr, model[7], model[8]);
        sendStrobe(1'b1, 1'b1, $urandom(), 4'd6, datapathPkg::opOr, 4'd6, 4'd7, 4'd8);
        waitDone();
        model[6] = result[31:0];
        compareAll("load and start together");

        endRun();
    end

endmodule
